// File: Makefile
TOP = tb_ecc_scratchpad
LOG = sim.log

.PHONY: all build run lint clean

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f rtl/*.sv sim/*.sv
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) --Mdir obj_dir -f files.f

# the simulation is run from the project root so the cases file is found
run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TB PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
rtl/ecc_pkg.sv
rtl/ecc_cmd_decode.sv
rtl/ecc_store_exec.sv
rtl/ecc_25_check.sv
rtl/ecc_scratchpad_top.sv
sim/tb_clock_gen.sv
sim/tb_ecc_scratchpad.sv

// File: rtl/ecc_25_check.sv
module ecc_25_check
    import ecc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              code_valid,
    input  logic              code_is_read,
    input  logic [code_w-1:0] code,
    input  logic              bypass,
    output logic              result_valid,
    output logic [data_w-1:0] rd_data,
    output logic              sbit_err,
    output logic              dbit_err
);

    logic [data_w-1:0] data_raw;
    logic [par_w-1:0]  par_raw;
    logic [par_w-1:0]  syndrome;
    logic [data_w-1:0] flip;
    logic              single;
    logic              double;

    assign data_raw = code[data_w-1:0];
    assign par_raw  = code[code_w-1:data_w];
    assign syndrome = par_raw ^ ecc_encode(data_raw);

    ////////////////////////////////////////////////////////////
    // syndrome decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        flip   = '0;
        single = 1'b0;
        double = 1'b0;
        // column of data bit i is the parity of a lone one at i
        for (int i = 0; i < data_w; i++) begin
            if (syndrome == ecc_encode(data_w'(1) << i)) begin
                flip[i] = 1'b1;
            end
        end
        if (syndrome == '0) begin
            single = 1'b0;
        end else if (flip != '0) begin
            single = 1'b1;           // data bit, corrected
        end else if ($onehot(syndrome)) begin
            single = 1'b1;           // parity bit hit, data intact
        end else begin
            double = 1'b1;           // even weight, uncorrectable
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            rd_data      <= '0;
            sbit_err     <= 1'b0;
            dbit_err     <= 1'b0;
        end else begin
            result_valid <= code_valid;
            if (code_valid) begin
                if (!code_is_read) begin
                    rd_data  <= '0;
                    sbit_err <= 1'b0;
                    dbit_err <= 1'b0;
                end else if (bypass) begin
                    rd_data  <= data_raw;   // raw word, no check
                    sbit_err <= 1'b0;
                    dbit_err <= 1'b0;
                end else begin
                    rd_data  <= data_raw ^ flip;
                    sbit_err <= single;
                    dbit_err <= double;
                end
            end
        end
    end

endmodule

// File: rtl/ecc_cmd_decode.sv
module ecc_cmd_decode
    import ecc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_take,
    input  cmd_word_u         cmd,
    output logic              op_valid,
    output logic [1:0]        op,
    output logic [addr_w-1:0] addr,
    output logic [data_w-1:0] wr_data,
    output logic [code_w-1:0] flip_mask
);

    logic [code_w-1:0] mask_next;

    // one- or two-hot mask, out of range index dropped
    always_comb begin
        mask_next = '0;
        if (cmd.inj.op == op_inject) begin
            if (cmd.inj.flip_a < code_w) begin
                mask_next[cmd.inj.flip_a] = 1'b1;
            end
            if (cmd.inj.flip_b_en && (cmd.inj.flip_b < code_w)) begin
                mask_next[cmd.inj.flip_b] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= cmd_take;   // single cycle strobe
        end
    end

    // fields only move on a taken command
    always_ff @(posedge clk) begin
        if (cmd_take) begin
            op        <= cmd.wr.op;
            addr      <= cmd.wr.addr;
            wr_data   <= cmd.wr.data;
            flip_mask <= mask_next;
        end
    end

endmodule

// File: rtl/ecc_pkg.sv
package ecc_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int data_w = 25;
    localparam int par_w  = 6;
    localparam int code_w = data_w + par_w;   // parity sits above data
    localparam int addr_w = 4;
    localparam int depth  = 1 << addr_w;

    localparam logic [1:0] op_read   = 2'b00;
    localparam logic [1:0] op_write  = 2'b01;
    localparam logic [1:0] op_inject = 2'b10;

    ////////////////////////////////////////////////////////////
    // command word, decoded by opcode
    ////////////////////////////////////////////////////////////
    typedef union packed {
        struct packed {
            logic [1:0]        op;
            logic [addr_w-1:0] addr;
            logic              rsvd;        // bit 25 unused
            logic [data_w-1:0] data;
        } wr;
        struct packed {
            logic [1:0]        op;
            logic [addr_w-1:0] addr;
            logic [4:0]        flip_a;      // codeword bit index
            logic [4:0]        flip_b;
            logic              flip_b_en;
            logic [14:0]       rsvd;
        } inj;
    } cmd_word_u;

    // parity columns, odd weight so double errors never alias a single
    function automatic logic [par_w-1:0] ecc_encode(input logic [data_w-1:0] d);
        logic [par_w-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13]
             ^ d[15] ^ d[17] ^ d[19] ^ d[21] ^ d[23];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13]
             ^ d[16] ^ d[17] ^ d[20] ^ d[21] ^ d[24];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15]
             ^ d[16] ^ d[17] ^ d[22] ^ d[23] ^ d[24];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[18] ^ d[19]
             ^ d[20] ^ d[21] ^ d[22] ^ d[23] ^ d[24];
        p[4] = d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[20] ^ d[21] ^ d[22] ^ d[23] ^ d[24];
        p[5] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12]
             ^ d[14] ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24];   // overall term
        return p;
    endfunction

endpackage

// File: rtl/ecc_scratchpad_top.sv
module ecc_scratchpad_top
    import ecc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  cmd_word_u         cmd,
    input  logic              bypass,
    output logic              ack,
    output logic [data_w-1:0] rd_data,
    output logic              sbit_err,
    output logic              dbit_err
);

    logic              cmd_take;
    logic              busy;
    logic              req_q;
    logic              op_valid;
    logic [1:0]        op;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wr_data;
    logic [code_w-1:0] flip_mask;
    logic              code_valid;
    logic [code_w-1:0] code;
    logic              code_is_read;
    logic              result_valid;

    ////////////////////////////////////////////////////////////
    // four-phase req/ack
    ////////////////////////////////////////////////////////////
    assign cmd_take = req && !ack && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack   <= 1'b0;
            busy  <= 1'b0;
            req_q <= 1'b0;
        end else begin
            req_q <= req;
            if (cmd_take) begin
                busy <= 1'b1;
            end else if (result_valid) begin
                busy <= 1'b0;   // ack takes over from here
            end
            if (result_valid) begin
                ack <= 1'b1;
            end else if (ack && !req_q) begin
                ack <= 1'b0;
            end
        end
    end

    ecc_cmd_decode i_cmd_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_take  (cmd_take),
        .cmd       (cmd),
        .op_valid  (op_valid),
        .op        (op),
        .addr      (addr),
        .wr_data   (wr_data),
        .flip_mask (flip_mask)
    );

    ecc_store_exec i_store_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .op           (op),
        .addr         (addr),
        .wr_data      (wr_data),
        .flip_mask    (flip_mask),
        .code_valid   (code_valid),
        .code         (code),
        .code_is_read (code_is_read)
    );

    ecc_25_check i_check (
        .clk          (clk),
        .rst_n        (rst_n),
        .code_valid   (code_valid),
        .code_is_read (code_is_read),
        .code         (code),
        .bypass       (bypass),
        .result_valid (result_valid),
        .rd_data      (rd_data),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err)
    );

endmodule

// File: rtl/ecc_store_exec.sv
module ecc_store_exec
    import ecc_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              op_valid,
    input  logic [1:0]        op,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wr_data,
    input  logic [code_w-1:0] flip_mask,
    output logic              code_valid,
    output logic [code_w-1:0] code,
    output logic              code_is_read
);

    logic [code_w-1:0] mem [depth];

    ////////////////////////////////////////////////////////////
    // codeword array
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (op_valid) begin
            code <= mem[addr];   // old contents, only used on read
            case (op)
                op_write: begin
                    mem[addr] <= {ecc_encode(wr_data), wr_data};
                end
                op_inject: begin
                    mem[addr] <= mem[addr] ^ flip_mask;
                end
                default: begin
                    // read leaves the array alone
                end
            endcase
        end
    end

    // every op strobes so top sequencing stays uniform
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            code_valid   <= 1'b0;
            code_is_read <= 1'b0;
        end else begin
            code_valid   <= op_valid;
            code_is_read <= op_valid && (op == op_read);
        end
    end

endmodule

// File: sim/ecc_scratchpad_cases.txt
# cmd(hex) bypass rd_data(hex) sbit dbit hold(extra cycles req stays high)
# write and inject expect zero data and flags
40ABCDEF 0 0000000 0 0 0
45234567 0 0000000 0 0 0
7DFFFFFF 0 0000000 0 0 1
64000001 0 0000000 0 0 0
00000000 0 0ABCDEF 0 0 0
04000000 0 1234567 0 0 0
3C000000 0 1FFFFFF 0 0 0
24000000 0 0000001 0 0 0
# single flips, data bits then parity bits
80A00000 0 0000000 0 0 3
00000000 0 0ABCDEF 1 0 0
87000000 0 0000000 0 0 0
04000000 0 1234567 1 0 2
BF600000 0 0000000 0 0 0
3C000000 0 1FFFFFF 1 0 0
A7C00000 0 0000000 0 0 0
24000000 0 0000001 1 0 0
# double flips return the raw word
49555555 0 0000000 0 0 0
880C8000 0 0000000 0 0 1
08000000 0 1554554 0 1 0
4CF0F0F0 0 0000000 0 0 0
8CFA8000 0 0000000 0 0 0
0C000000 0 0F0F070 0 1 0
# bypass reads
08000000 1 1554554 0 0 0
00000000 1 0ABCDCF 0 0 2
00000000 0 0ABCDEF 1 0 0
# rewrite clears the error, neighbour untouched
40000000 0 0000000 0 0 2
00000000 0 0000000 0 0 0
04000000 0 1234567 1 0 0
# flip_b index 31 is out of range and dropped
55000000 0 0000000 0 0 0
961F8000 0 0000000 0 0 0
14000000 0 1000000 1 0 0

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 2;   // 4 ns clock
    localparam int reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // released on a falling edge like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: sim/tb_ecc_scratchpad.sv
module tb_ecc_scratchpad
    import ecc_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic              clk;
    logic              rst_n;
    logic              req;
    logic              bypass;
    cmd_word_u         cmd;
    logic              ack;
    logic [data_w-1:0] rd_data;
    logic              sbit_err;
    logic              dbit_err;
    logic              cases_loaded;

    // one entry per transaction
    logic [31:0]       cmd_q[$];
    logic              bypass_q[$];
    logic [data_w-1:0] data_q[$];
    logic              sbit_q[$];
    logic              dbit_q[$];
    int                hold_q[$];

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ecc_scratchpad_top i_ecc_scratchpad_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .cmd      (cmd),
        .bypass   (bypass),
        .ack      (ack),
        .rd_data  (rd_data),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h",
                                $time, name, got, expected));
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_cmd;
        logic [31:0] f_byp;
        logic [31:0] f_data;
        logic [31:0] f_sbit;
        logic [31:0] f_dbit;
        int          f_hold;
        fd = $fopen("sim/ecc_scratchpad_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open sim/ecc_scratchpad_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                    continue;   // comment or blank
                end
                n = $sscanf(line, "%h %h %h %h %h %d",
                            f_cmd, f_byp, f_data, f_sbit, f_dbit, f_hold);
                if (n != 6) begin
                    abort_run($sformatf("malformed line in cases file: %s", line));
                end else begin
                    cmd_q.push_back(f_cmd);
                    bypass_q.push_back(f_byp[0]);
                    data_q.push_back(f_data[data_w-1:0]);
                    sbit_q.push_back(f_sbit[0]);
                    dbit_q.push_back(f_dbit[0]);
                    hold_q.push_back(f_hold);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_results(input int idx);
        check_value("rd_data", 32'(rd_data), 32'(data_q[idx]));
        check_value("sbit_err", 32'(sbit_err), 32'(sbit_q[idx]));
        check_value("dbit_err", 32'(dbit_err), 32'(dbit_q[idx]));
    endtask

    // one four-phase transaction, inputs move on falling edges only
    task automatic run_case(input int idx);
        cmd    = cmd_q[idx];
        bypass = bypass_q[idx];
        req    = 1'b1;
        do @(negedge clk); while (ack !== 1'b1);
        check_results(idx);
        repeat (hold_q[idx]) begin   // back-pressure, result must hold
            @(negedge clk);
            check_value("ack", 32'(ack), 32'd1);
            check_results(idx);
        end
        req = 1'b0;
        do @(negedge clk); while (ack !== 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        req          = 1'b0;
        bypass       = 1'b0;
        cmd          = '0;
        cases_loaded = 1'b0;
        load_cases();
        if (cmd_q.size() == 0) begin
            abort_run("the cases file holds no transactions");
        end else begin
            cases_loaded = 1'b1;
            wait (rst_n === 1'b1);
            @(negedge clk);
            for (int i = 0; i < cmd_q.size(); i++) begin
                run_case(i);
            end
            $display("TB PASSED");
            $finish;
        end
    end

    initial begin
        wait (cases_loaded);
        #(cmd_q.size() * 20 * 4 + 16);   // 20 cycles per case plus reset
        abort_run("timeout: the req/ack handshake never completed");
    end

endmodule
